// File: source/wave_pkg.sv
package wave_pkg;

    // audio sample and screen level widths
    localparam int SAMPLE_WIDTH = 16;
    localparam int LEVEL_WIDTH  = 8;

    // one capture buffer holds a full screen of samples
    localparam int INDEX_WIDTH  = 8;
    localparam int BUFFER_DEPTH = 256;

    // level of a zero sample, middle of the screen
    localparam int LEVEL_CENTER = 128;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [LEVEL_WIDTH-1:0] level_t;

    // one write into the hidden bank of the sample memory
    typedef struct packed {
        logic                   valid;
        logic                   bank;
        logic [INDEX_WIDTH-1:0] index;
        level_t                 level;
    } capture_write_t;

endpackage

// File: source/display_pkg.sv
package display_pkg;

    import wave_pkg::*;

    // one column per captured sample
    localparam int COLUMN_COUNT = 256;

    // read address into the visible bank
    typedef struct packed {
        logic                   bank;
        logic [INDEX_WIDTH-1:0] index;
    } display_read_t;

    // x position with the vertical line span drawn in that column
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] x;
        level_t                 y_top;
        level_t                 y_bottom;
    } column_t;

endpackage

// File: source/wave_capture.sv
`timescale 1ns/1ps

module wave_capture
    import wave_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           new_sample_ready,
    input  sample_t        new_sample_in,
    input  logic           display_idle,
    output capture_write_t capture_write,
    output logic           read_index
);

    typedef enum logic {
        ARMED  = 1'b0,
        ACTIVE = 1'b1
    } capture_state_e;

    capture_state_e state;

    // last accepted sample, compared against the incoming one
    sample_t prev_sample;
    logic    crossing;

    logic [INDEX_WIDTH-1:0] index_count;
    logic                   last_index;
    logic                   take_sample;

    logic                   buffer_full;
    logic                   flip;

    // registered write payload
    logic                   wr_valid;
    logic [INDEX_WIDTH-1:0] wr_index;
    level_t                 wr_level;
    level_t                 new_level;

    // rising zero crossing: previous negative, current nonnegative
    assign crossing = prev_sample[SAMPLE_WIDTH-1] && !new_sample_in[SAMPLE_WIDTH-1];

    assign last_index = (index_count == INDEX_WIDTH'(BUFFER_DEPTH - 1));

    // a sample is stored if the capture is running or this one triggers it
    assign take_sample = new_sample_ready && ((state == ACTIVE) || crossing);

    // upper byte of the sample, flipped so positive values sit higher on screen
    assign new_level = level_t'(LEVEL_CENTER) - new_sample_in[SAMPLE_WIDTH-1 -: LEVEL_WIDTH];

    // swap banks only between captures and between scans
    assign flip = buffer_full && display_idle && (state == ARMED);

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_sample <= '0;
        end else if (new_sample_ready) begin
            prev_sample <= new_sample_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARMED;
        end else if (new_sample_ready) begin
            case (state)
                ARMED:  if (crossing) state <= ACTIVE;
                ACTIVE: if (last_index) state <= ARMED;
                default: state <= ARMED;
            endcase
        end
    end

    // stays at zero while armed, wraps back to zero after the last sample
    always_ff @(posedge clk) begin
        if (reset) begin
            index_count <= '0;
        end else if (take_sample) begin
            index_count <= index_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buffer_full <= 1'b0;
            read_index  <= 1'b0;
        end else if (flip) begin
            buffer_full <= 1'b0;
            read_index  <= ~read_index;
        end else if (take_sample && (state == ACTIVE) && last_index) begin
            buffer_full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= take_sample;
        end
    end

    always_ff @(posedge clk) begin
        if (take_sample) begin
            wr_index <= index_count;
            wr_level <= new_level;
        end
    end

    // bank follows read_index live so a swap never lands a write in the visible bank
    assign capture_write = '{
        valid: wr_valid,
        bank:  ~read_index,
        index: wr_index,
        level: wr_level
    };

    // only the trigger sample may be written by a stage that was armed
    a_armed_write_index0: assert property (
        @(posedge clk) disable iff (reset)
        capture_write.valid |-> ($past(state) == ACTIVE) || (capture_write.index == '0)
    );

    // the visible bank changes only after a cycle with the display idle
    a_flip_while_idle: assert property (
        @(posedge clk) disable iff (reset)
        $changed(read_index) |-> $past(display_idle)
    );

endmodule

// File: source/capture_ram.sv
`timescale 1ns/1ps

module capture_ram
    import wave_pkg::*;
    import display_pkg::*;
(
    input  logic           clk,
    input  capture_write_t capture_write,
    input  display_read_t  read_request,
    output level_t         read_level
);

    localparam int RAM_DEPTH = 2 * BUFFER_DEPTH;

    // two banks, bank bit on top of the address
    level_t mem [RAM_DEPTH];

    logic [INDEX_WIDTH:0] write_address;
    logic [INDEX_WIDTH:0] read_address;

    assign write_address = {capture_write.bank, capture_write.index};
    assign read_address  = {read_request.bank, read_request.index};

    always_ff @(posedge clk) begin
        if (capture_write.valid) begin
            mem[write_address] <= capture_write.level;
        end
    end

    // registered read, level shows up one cycle after the address
    always_ff @(posedge clk) begin
        read_level <= mem[read_address];
    end

    // capture and display must always sit in opposite banks
    a_bank_separation: assert property (
        @(posedge clk)
        capture_write.valid |-> (capture_write.bank != read_request.bank)
    );

endmodule

// File: source/wave_display.sv
`timescale 1ns/1ps

module wave_display
    import wave_pkg::*;
    import display_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          frame_start,
    input  logic          read_index,
    input  level_t        read_level,
    output display_read_t read_request,
    output logic          column_valid,
    output column_t       column,
    output logic          display_idle
);

    logic                   scanning;
    logic [INDEX_WIDTH-1:0] scan_index;
    logic                   scan_last;

    // stage tracking the memory latency
    logic                   level_valid;
    logic [INDEX_WIDTH-1:0] level_x;

    // level of the column before the current one
    level_t                 prev_level;
    level_t                 span_low;
    level_t                 span_high;

    assign scan_last = (scan_index == INDEX_WIDTH'(COLUMN_COUNT - 1));

    // idle only once the last column has left the pipeline
    assign display_idle = !(scanning || level_valid || column_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            scanning   <= 1'b0;
            scan_index <= '0;
        end else if (scanning) begin
            scan_index <= scan_index + 1'b1;
            if (scan_last) begin
                scanning <= 1'b0;
            end
        end else if (frame_start && display_idle) begin
            scanning   <= 1'b1;
            scan_index <= '0;
        end
    end

    // request is driven every cycle, only used while scanning
    assign read_request = '{bank: read_index, index: scan_index};

    always_ff @(posedge clk) begin
        if (reset) begin
            level_valid  <= 1'b0;
            column_valid <= 1'b0;
        end else begin
            level_valid  <= scanning;
            column_valid <= level_valid;
        end
    end

    always_ff @(posedge clk) begin
        level_x <= scan_index;
    end

    // column 0 has no neighbour so its span collapses to one point
    always_comb begin
        if (level_x == '0) begin
            span_low  = read_level;
            span_high = read_level;
        end else if (read_level < prev_level) begin
            span_low  = read_level;
            span_high = prev_level;
        end else begin
            span_low  = prev_level;
            span_high = read_level;
        end
    end

    always_ff @(posedge clk) begin
        if (level_valid) begin
            prev_level <= read_level;
            column     <= '{x: level_x, y_top: span_low, y_bottom: span_high};
        end
    end

    // columns of one scan come out back to back in order
    a_column_step: assert property (
        @(posedge clk) disable iff (reset)
        column_valid && $past(column_valid) |->
            column.x == INDEX_WIDTH'($past(column.x) + 1'b1)
    );

endmodule

// File: source/scope_top.sv
`timescale 1ns/1ps

module scope_top
    import wave_pkg::*;
    import display_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    new_sample_ready,
    input  sample_t new_sample_in,
    input  logic    frame_start,
    output logic    column_valid,
    output column_t column,
    output logic    display_idle,
    output logic    read_index
);

    capture_write_t capture_write;
    display_read_t  read_request;
    level_t         read_level;

    // trigger and store into the hidden bank
    wave_capture u_wave_capture (
        .clk              (clk),
        .reset            (reset),
        .new_sample_ready (new_sample_ready),
        .new_sample_in    (new_sample_in),
        .display_idle     (display_idle),
        .capture_write    (capture_write),
        .read_index       (read_index)
    );

    capture_ram u_capture_ram (
        .clk           (clk),
        .capture_write (capture_write),
        .read_request  (read_request),
        .read_level    (read_level)
    );

    // scan the visible bank on each frame
    wave_display u_wave_display (
        .clk          (clk),
        .reset        (reset),
        .frame_start  (frame_start),
        .read_index   (read_index),
        .read_level   (read_level),
        .read_request (read_request),
        .column_valid (column_valid),
        .column       (column),
        .display_idle (display_idle)
    );

endmodule

// File: dv/scope_tb.sv
`timescale 1ns/1ps

module scope_tb
    import wave_pkg::*;
    import display_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    // new_sample_ready pulses are this many cycles apart
    localparam int SAMPLE_GAP = 5;
    localparam int FIRST_COLUMN_LATENCY = 3;
    localparam int FRAME_CYCLES = 300;
    localparam int RANDOM_ROUNDS = 5;
    localparam int RANDOM_SAMPLES = 400;
    // directed tests send 286 + 520 + 272 + 257 samples over 6 frames
    localparam int TOTAL_SAMPLES = 1335 + RANDOM_ROUNDS * RANDOM_SAMPLES;
    localparam int TOTAL_FRAMES = 6 + RANDOM_ROUNDS;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + TOTAL_SAMPLES * SAMPLE_GAP + TOTAL_FRAMES * FRAME_CYCLES);

    logic    clk;
    logic    reset;
    logic    new_sample_ready;
    sample_t new_sample_in;
    logic    frame_start;
    logic    column_valid;
    column_t column;
    logic    display_idle;
    logic    read_index;

    // reference model of the capture side
    sample_t model_prev;
    bit      model_active;
    int      model_index;
    bit      model_full;
    logic    model_read_index;
    level_t  model_mem [2][BUFFER_DEPTH];
    bit      bank_valid [2];

    column_t     frame_cols [COLUMN_COUNT];
    column_t     prev_frame_cols [COLUMN_COUNT];
    bit          scan_running;
    logic [31:0] lcg_state;
    string       current_test;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          cycle_count;

    scope_top DUT (
        .clk              (clk),
        .reset            (reset),
        .new_sample_ready (new_sample_ready),
        .new_sample_in    (new_sample_in),
        .frame_start      (frame_start),
        .column_valid     (column_valid),
        .column           (column),
        .display_idle     (display_idle),
        .read_index       (read_index)
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // screen level is 128 minus the upper byte, wrapping at 256
    function automatic level_t expected_level(input sample_t s);
        int upper_byte;
        upper_byte = int'(s) >>> (SAMPLE_WIDTH - LEVEL_WIDTH);
        return level_t'(LEVEL_CENTER - upper_byte);
    endfunction

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h",
                     current_test, label, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("[%s] %s", current_test, what);
    endtask

    task automatic model_sample(input sample_t s);
        int hidden;
        hidden = model_read_index ? 0 : 1;
        if (model_active) begin
            model_mem[hidden][model_index] = expected_level(s);
            model_index++;
            if (model_index == BUFFER_DEPTH) begin
                model_active = 1'b0;
                model_full = 1'b1;
                model_index = 0;
                bank_valid[hidden] = 1'b1;
            end
        end else if (model_prev < 0 && s >= 0) begin
            model_mem[hidden][0] = expected_level(s);
            model_index = 1;
            model_active = 1'b1;
        end
        model_prev = s;
    endtask

    // banks swap once a full buffer waits, the stage is armed and no scan runs
    task automatic model_flip();
        if (model_full && !model_active) begin
            model_full = 1'b0;
            model_read_index = ~model_read_index;
        end
    endtask

    task automatic send_sample(input sample_t s);
        @(negedge clk);
        new_sample_in = s;
        new_sample_ready = 1'b1;
        @(negedge clk);
        new_sample_ready = 1'b0;
        repeat (SAMPLE_GAP - 2) @(negedge clk);
        model_sample(s);
        if (!scan_running) model_flip();
    endtask

    task automatic compare_columns();
        int     bank;
        int     i;
        level_t lv;
        level_t pv;
        bank = int'(model_read_index);
        for (i = 0; i < COLUMN_COUNT; i++) begin
            check_value($sformatf("column %0d x", i), i, frame_cols[i].x);
            if (bank_valid[bank]) begin
                lv = model_mem[bank][i];
                pv = (i == 0) ? lv : model_mem[bank][i-1];
                check_value($sformatf("column %0d y_top", i), (lv < pv) ? lv : pv,
                            frame_cols[i].y_top);
                check_value($sformatf("column %0d y_bottom", i), (lv < pv) ? pv : lv,
                            frame_cols[i].y_bottom);
            end
        end
    endtask

    // extra_start_at pulses frame_start again at that cycle of the scan
    task automatic run_frame(input int extra_start_at);
        int   count;
        int   cycles;
        int   first_cycle;
        int   extra;
        logic start_index;
        bit   index_moved;
        scan_running = 1'b1;
        prev_frame_cols = frame_cols;
        @(negedge clk);
        check_value("read_index at frame start", model_read_index, read_index);
        start_index = read_index;
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        count = 0;
        cycles = 1;
        first_cycle = 0;
        index_moved = 1'b0;
        while (count < COLUMN_COUNT && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
            frame_start = (cycles == extra_start_at);
            if (column_valid) begin
                if (count == 0) first_cycle = cycles;
                frame_cols[count] = column;
                count++;
            end
            if (read_index !== start_index) index_moved = 1'b1;
        end
        frame_start = 1'b0;
        if (index_moved) report_failure("read_index changed while a scan was running");
        check_value("columns in frame", COLUMN_COUNT, count);
        check_value("first column latency", FIRST_COLUMN_LATENCY, first_cycle);
        compare_columns();
        cycles = 0;
        while (!display_idle && cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        if (!display_idle) report_failure("display_idle stayed low after the last column");
        check_value("cycles from last column to idle", 1, cycles);
        extra = 0;
        repeat (8) begin
            @(negedge clk);
            if (column_valid) extra++;
        end
        check_value("columns after frame", 0, extra);
        scan_running = 1'b0;
        model_flip();
    endtask

    task automatic finish_test(input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: PASS", current_test);
        end else begin
            failed_tests++;
            $display("test %s: FAIL, %0d errors", current_test, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int errors_before;
        current_test = "reset_state";
        errors_before = error_count;
        check_value("column_valid", 0, column_valid);
        check_value("display_idle", 1, display_idle);
        check_value("read_index", 0, read_index);
        run_frame(-1);
        finish_test(errors_before);
    endtask

    task automatic test_triggered_capture();
        int   errors_before;
        int   k;
        logic start_index;
        current_test = "triggered_capture";
        errors_before = error_count;
        start_index = read_index;
        // ramp crosses zero at the 31st sample
        for (k = 0; k < 286; k++) send_sample(sample_t'(-3000 + k * 100));
        check_value("read_index toggled", !start_index, read_index);
        run_frame(-1);
        check_value("crossing sample level", expected_level(0), frame_cols[0].y_top);
        finish_test(errors_before);
    endtask

    task automatic test_no_trigger();
        int   errors_before;
        int   k;
        logic start_index;
        current_test = "no_trigger";
        errors_before = error_count;
        start_index = read_index;
        // each run is long enough that a false trigger would fill a buffer
        for (k = 0; k < 260; k++) send_sample(sample_t'(200 + k * 50));
        for (k = 0; k < 260; k++) send_sample(sample_t'(-200 - k * 50));
        check_value("read_index unchanged", start_index, read_index);
        run_frame(-1);
        for (k = 0; k < COLUMN_COUNT; k++) begin
            check_value($sformatf("column %0d repeat", k), prev_frame_cols[k], frame_cols[k]);
        end
        finish_test(errors_before);
    endtask

    task automatic test_line_spans();
        int errors_before;
        int k;
        current_test = "line_spans";
        errors_before = error_count;
        for (k = 0; k < 272; k++) send_sample(sample_t'(-8192 + (k % 32) * 512));
        run_frame(-1);
        // capture starts on the zero sample of a tooth
        check_value("column 0 y_top", expected_level(0), frame_cols[0].y_top);
        check_value("column 0 y_bottom", expected_level(0), frame_cols[0].y_bottom);
        for (k = 0; k < COLUMN_COUNT; k++) begin
            if (frame_cols[k].y_top > frame_cols[k].y_bottom) begin
                report_failure($sformatf("column %0d has y_top below y_bottom", k));
            end
        end
        finish_test(errors_before);
    endtask

    task automatic test_deferred_flip();
        int   errors_before;
        int   k;
        logic start_index;
        current_test = "deferred_flip";
        errors_before = error_count;
        start_index = read_index;
        send_sample(sample_t'(-1000));
        for (k = 0; k < 250; k++) send_sample(sample_t'(k * 64));
        // capture finishes early in the scan, which still shows the old buffer
        fork
            run_frame(100);
            begin
                repeat (10) @(negedge clk);
                for (int j = 250; j < 256; j++) send_sample(sample_t'(j * 64));
            end
        join
        check_value("read_index after scan", !start_index, read_index);
        run_frame(-1);
        check_value("new capture first level", expected_level(0), frame_cols[0].y_top);
        finish_test(errors_before);
    endtask

    task automatic test_random_stream();
        int errors_before;
        int r;
        int k;
        current_test = "random_stream";
        errors_before = error_count;
        for (r = 0; r < RANDOM_ROUNDS; r++) begin
            for (k = 0; k < RANDOM_SAMPLES; k++) begin
                lcg_state = lcg_next(lcg_state);
                send_sample(sample_t'(lcg_state[31:16]));
            end
            run_frame(-1);
        end
        finish_test(errors_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        new_sample_ready = 1'b0;
        new_sample_in = '0;
        frame_start = 1'b0;
        model_prev = '0;
        model_active = 1'b0;
        model_index = 0;
        model_full = 1'b0;
        model_read_index = 1'b0;
        bank_valid[0] = 1'b0;
        bank_valid[1] = 1'b0;
        scan_running = 1'b0;
        lcg_state = 32'h7846_cfc0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_triggered_capture();
        test_no_trigger();
        test_line_spans();
        test_deferred_flip();
        test_random_stream();
        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sources.f
source/wave_pkg.sv
source/display_pkg.sv
source/wave_capture.sv
source/capture_ram.sv
source/wave_display.sv
source/scope_top.sv
dv/scope_tb.sv

// File: Makefile
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= scope_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	set -o pipefail; ./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "failure reported in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
